// File: common/tlboper_params.svh
// width and count macros for the jTLB operation controller, included by RTL and testbench
`ifndef TLBOPER_PARAMS_SVH
`define TLBOPER_PARAMS_SVH

// entry field widths
`define TLBOPER_VPN_WIDTH   27
`define TLBOPER_PPN_WIDTH   28
`define TLBOPER_ASID_WIDTH  16
`define TLBOPER_FLG_WIDTH   14
`define TLBOPER_PGS_WIDTH   3

// index register, bits 9..8 pick the bank
`define TLBOPER_MIR_WIDTH   10

// jTLB geometry
`define TLBOPER_IDX_WIDTH   9
`define TLBOPER_BANKS       4

// valid + vpn + asid + pgs + global
`define TLBOPER_TAG_WIDTH   48
// ppn + flags
`define TLBOPER_DATA_WIDTH  42

// invalidate-all sweeps from here down to 0
`define TLBOPER_INVALL_LAST 255

`endif

// File: common/tlboper_pkg.sv
// shared operation, phase and bus types of the jTLB operation controller, used by scoped name
`default_nettype none

`include "tlboper_params.svh"

package tlboper_pkg;

  // operation held by the decode stage
  typedef enum logic [2:0] {
    op_none   = 3'd0,
    op_tlbp   = 3'd1,
    op_tlbr   = 3'd2,
    op_tlbwi  = 3'd3,
    op_tlbwr  = 3'd4,
    op_invall = 3'd5
  } tlb_op_e;

  // sequencer phases
  typedef enum logic [2:0] {
    ph_idle    = 3'd0,
    ph_req     = 3'd1,
    ph_wait    = 3'd2,
    ph_wr_req  = 3'd3,
    ph_wr_wait = 3'd4
  } tlb_phase_e;

  // software strobes from the register block
  typedef struct packed {
    logic invall;
    logic tlbwr;
    logic tlbwi;
    logic tlbr;
    logic tlbp;
  } tlb_cmd_t;

  // current entry as held by the register block
  typedef struct packed {
    logic [`TLBOPER_VPN_WIDTH-1:0]  vpn;
    logic [`TLBOPER_ASID_WIDTH-1:0] asid;
    logic [`TLBOPER_PGS_WIDTH-1:0]  pgs;
    logic                           glb;
    logic [`TLBOPER_PPN_WIDTH-1:0]  ppn;
    logic [`TLBOPER_FLG_WIDTH-1:0]  flg;
  } tlb_entry_t;

  // request to the jTLB arbiter
  typedef struct packed {
    logic                           req;
    logic                           write;
    logic                           fifo_write;
    logic                           idx_not_va;
    logic                           cmp_va;
    logic [`TLBOPER_BANKS-1:0]      bank_sel;
    logic [`TLBOPER_IDX_WIDTH-1:0]  idx;
    logic [`TLBOPER_VPN_WIDTH-1:0]  vpn;
    logic [`TLBOPER_TAG_WIDTH-1:0]  tag_din;
    logic [`TLBOPER_DATA_WIDTH-1:0] data_din;
    logic [`TLBOPER_BANKS-1:0]      fifo_din;
  } tlb_arb_req_t;

  // jTLB access response, sel is the victim bank of a read
  typedef struct packed {
    logic                      cmplt;
    logic [`TLBOPER_BANKS-1:0] fifo;
    logic [`TLBOPER_BANKS-1:0] sel;
  } tlb_jtlb_rsp_t;

endpackage

`default_nettype wire

// File: tlboper/tlboper_decode.sv
// decode stage, latches one software TLB operation and holds it until the sequencer ends it
`default_nettype none

module tlboper_decode (
  input  wire                        tlboper_clk,
  input  wire                        cpurst_b,
  input  wire tlboper_pkg::tlb_cmd_t cmd,
  input  wire                        op_done,
  output tlboper_pkg::tlb_op_e       cur_op
);

  tlboper_pkg::tlb_op_e strobe_op;

  // ==============================
  // strobe encode
  // ==============================
  // fixed priority, invall first
  always_comb
  begin
    if (cmd.invall)
      strobe_op = tlboper_pkg::op_invall;
    else if (cmd.tlbwr)
      strobe_op = tlboper_pkg::op_tlbwr;
    else if (cmd.tlbwi)
      strobe_op = tlboper_pkg::op_tlbwi;
    else if (cmd.tlbr)
      strobe_op = tlboper_pkg::op_tlbr;
    else if (cmd.tlbp)
      strobe_op = tlboper_pkg::op_tlbp;
    else
      strobe_op = tlboper_pkg::op_none;
  end

  // ==============================
  // operation register
  // ==============================
  // strobes while busy are dropped, including the done cycle
  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_op <= tlboper_pkg::op_none;
    else if (op_done)
      cur_op <= tlboper_pkg::op_none;
    else if (cur_op == tlboper_pkg::op_none)
      cur_op <= strobe_op;
  end

  // register block never raises two strobes at once
  a_cmd_onehot: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    $onehot0(cmd));

  // a running operation only ends through the sequencer
  a_op_hold: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (cur_op != tlboper_pkg::op_none) && !op_done |=> $stable(cur_op));

endmodule

`default_nettype wire

// File: tlboper/tlboper_seq.sv
// execute stage, steps each operation through its request, grant and completion phases
`default_nettype none

`include "tlboper_params.svh"

module tlboper_seq (
  input  wire                             tlboper_clk,
  input  wire                             cpurst_b,
  input  wire tlboper_pkg::tlb_op_e       cur_op,
  input  wire                             arb_grant,
  input  wire tlboper_pkg::tlb_jtlb_rsp_t jtlb_rsp,
  output tlboper_pkg::tlb_phase_e         phase,
  output logic [`TLBOPER_IDX_WIDTH-1:0]   inv_idx,
  output logic [`TLBOPER_BANKS-1:0]       wr_fifo,
  output logic [`TLBOPER_BANKS-1:0]       wr_sel,
  output logic                            op_done
);

  localparam int IDX_W = `TLBOPER_IDX_WIDTH;
  localparam logic [IDX_W-1:0] INV_FIRST = IDX_W'(`TLBOPER_INVALL_LAST);

  tlboper_pkg::tlb_phase_e phase_q;
  tlboper_pkg::tlb_phase_e phase_nxt;
  logic                    is_invall;
  logic                    is_tlbwr;
  logic                    inv_last;
  logic                    inv_dec;
  logic                    rd_capture;

  assign is_invall = (cur_op == tlboper_pkg::op_invall);
  assign is_tlbwr  = (cur_op == tlboper_pkg::op_tlbwr);
  assign inv_last  = (inv_idx == '0);

  // ==============================
  // phase FSM
  // ==============================
  // the register rests in ph_req, so the first request goes out
  // in the cycle right after the strobe is latched
  assign phase = (cur_op == tlboper_pkg::op_none) ? tlboper_pkg::ph_idle : phase_q;

  always_comb
  begin
    phase_nxt = phase_q;
    case (phase)
      tlboper_pkg::ph_req:
      begin
        // invall keeps requesting through the whole sweep
        if (arb_grant && !is_invall)
          phase_nxt = tlboper_pkg::ph_wait;
      end
      tlboper_pkg::ph_wait:
      begin
        if (jtlb_rsp.cmplt && is_tlbwr)
          phase_nxt = tlboper_pkg::ph_wr_req;
        else if (jtlb_rsp.cmplt)
          phase_nxt = tlboper_pkg::ph_req;
      end
      tlboper_pkg::ph_wr_req:
      begin
        if (arb_grant)
          phase_nxt = tlboper_pkg::ph_wr_wait;
      end
      tlboper_pkg::ph_wr_wait:
      begin
        if (jtlb_rsp.cmplt)
          phase_nxt = tlboper_pkg::ph_req;
      end
      default:
      begin
        phase_nxt = tlboper_pkg::ph_req;
      end
    endcase
  end

  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      phase_q <= tlboper_pkg::ph_req;
    else
      phase_q <= phase_nxt;
  end

  // invall finishes on its last grant, no jTLB completion awaited
  assign op_done = ((phase == tlboper_pkg::ph_req) && arb_grant && is_invall && inv_last)
                || ((phase == tlboper_pkg::ph_wait) && jtlb_rsp.cmplt && !is_tlbwr)
                || ((phase == tlboper_pkg::ph_wr_wait) && jtlb_rsp.cmplt);

  // ==============================
  // invall index counter
  // ==============================
  assign inv_dec = (phase == tlboper_pkg::ph_req) && arb_grant && is_invall && !inv_last;

  // reloaded at every completion so the next sweep starts at the top
  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inv_idx <= INV_FIRST;
    else if (op_done)
      inv_idx <= INV_FIRST;
    else if (inv_dec)
      inv_idx <= inv_idx - 1'b1;
  end

  // ==============================
  // tlbwr victim capture
  // ==============================
  assign rd_capture = (phase == tlboper_pkg::ph_wait) && jtlb_rsp.cmplt && is_tlbwr;

  always_ff @(posedge tlboper_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_fifo <= '0;
      wr_sel  <= '0;
    end
    else if (rd_capture)
    begin
      wr_fifo <= jtlb_rsp.fifo;
      wr_sel  <= jtlb_rsp.sel;
    end
  end

  // held request is only retired by the arbiter
  a_req_until_grant: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    (phase == tlboper_pkg::ph_req) && !arb_grant |=> (phase == tlboper_pkg::ph_req));

  // counter moves down by one or reloads, never wraps below zero
  a_inv_step: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    $changed(inv_idx) |-> (inv_idx == INV_FIRST)
      || (($past(inv_idx) != '0) && (inv_idx == IDX_W'($past(inv_idx) - 1'b1))));

endmodule

`default_nettype wire

// File: tlboper/tlboper_jtlb_req.sv
// result stage, forms the jTLB arbiter request fields and the completion pulses
`default_nettype none

`include "tlboper_params.svh"

module tlboper_jtlb_req (
  input  wire tlboper_pkg::tlb_op_e       cur_op,
  input  wire tlboper_pkg::tlb_phase_e    phase,
  input  wire [`TLBOPER_IDX_WIDTH-1:0]    inv_idx,
  input  wire [`TLBOPER_BANKS-1:0]        wr_fifo,
  input  wire [`TLBOPER_BANKS-1:0]        wr_sel,
  input  wire                             op_done,
  input  wire tlboper_pkg::tlb_entry_t    entry,
  input  wire [`TLBOPER_MIR_WIDTH-1:0]    mir,
  output tlboper_pkg::tlb_arb_req_t       arb,
  output logic                            tlbp_cmplt,
  output logic                            tlbr_cmplt,
  output logic                            cmplt,
  output logic                            cp0_tlb_done
);

  localparam int BANKS = `TLBOPER_BANKS;
  localparam int SEL_W = $clog2(BANKS);
  localparam int MIR_W = `TLBOPER_MIR_WIDTH;
  localparam int IDX_W = `TLBOPER_IDX_WIDTH;

  logic             rd_req;
  logic             wr_req;
  logic             is_tlbp;
  logic             is_tlbr;
  logic             is_tlbwi;
  logic             is_invall;
  logic             tag_vld;
  logic [BANKS-1:0] idx_sel;

  assign rd_req    = (phase == tlboper_pkg::ph_req);
  assign wr_req    = (phase == tlboper_pkg::ph_wr_req);
  assign is_tlbp   = (cur_op == tlboper_pkg::op_tlbp);
  assign is_tlbr   = (cur_op == tlboper_pkg::op_tlbr);
  assign is_tlbwi  = (cur_op == tlboper_pkg::op_tlbwi);
  assign is_invall = (cur_op == tlboper_pkg::op_invall);

  // one-hot bank from the top bits of mir
  assign idx_sel = BANKS'(1) << mir[MIR_W-1 -: SEL_W];

  // only real writes carry a valid entry, invalidates write zeros
  assign tag_vld = (rd_req && is_tlbwi) || wr_req;

  // ==============================
  // arbiter request
  // ==============================
  always_comb
  begin
    arb            = '0;
    arb.req        = rd_req || wr_req;
    arb.write      = (rd_req && (is_tlbwi || is_invall)) || wr_req;
    arb.fifo_write = (rd_req && is_invall) || wr_req;
    arb.idx_not_va = rd_req && (is_tlbr || is_tlbwi || is_invall);
    arb.cmp_va     = rd_req && is_tlbp;
    arb.idx        = is_invall ? inv_idx : mir[IDX_W-1:0];
    arb.vpn        = entry.vpn;
    if (wr_req)
      arb.bank_sel = wr_sel;
    else if (rd_req && (is_tlbr || is_tlbwi))
      arb.bank_sel = idx_sel;
    else if (rd_req)
      arb.bank_sel = '1;
    if (tag_vld)
    begin
      arb.tag_din  = {1'b1, entry.vpn, entry.asid, entry.pgs, entry.glb};
      arb.data_din = {entry.ppn, entry.flg};
    end
    // rotate the fifo bits so the next victim moves on
    if (is_invall)
      arb.fifo_din = BANKS'(1);
    else
      arb.fifo_din = {wr_fifo[BANKS-2:0], wr_fifo[BANKS-1]};
  end

  // ==============================
  // completion to register block
  // ==============================
  assign cmplt        = op_done;
  assign tlbp_cmplt   = op_done && is_tlbp;
  assign tlbr_cmplt   = op_done && is_tlbr;
  assign cp0_tlb_done = op_done && is_invall;

  // victim bank from the jTLB read must select a single way
  always_comb
  begin
    if (arb.req && arb.write && !is_invall)
      a_one_bank: assert final ($onehot0(arb.bank_sel));
  end

endmodule

`default_nettype wire

// File: tlboper/tlboper_top.sv
// top of the jTLB operation controller, connects decode, sequencer and request former
`default_nettype none

`include "tlboper_params.svh"

module tlboper_top (
  input  wire                             tlboper_clk,
  input  wire                             cpurst_b,
  input  wire tlboper_pkg::tlb_cmd_t      cmd,
  input  wire tlboper_pkg::tlb_entry_t    entry,
  input  wire [`TLBOPER_MIR_WIDTH-1:0]    mir,
  input  wire                             arb_grant,
  input  wire tlboper_pkg::tlb_jtlb_rsp_t jtlb_rsp,
  output tlboper_pkg::tlb_arb_req_t       arb,
  output logic                            tlbp_cmplt,
  output logic                            tlbr_cmplt,
  output logic                            cmplt,
  output logic                            cp0_tlb_done
);

  tlboper_pkg::tlb_op_e             cur_op;
  tlboper_pkg::tlb_phase_e          phase;
  logic [`TLBOPER_IDX_WIDTH-1:0]    inv_idx;
  logic [`TLBOPER_BANKS-1:0]        wr_fifo;
  logic [`TLBOPER_BANKS-1:0]        wr_sel;
  logic                             op_done;

  // ==============================
  // decode
  // ==============================
  tlboper_decode decode_i (
    .tlboper_clk (tlboper_clk),
    .cpurst_b    (cpurst_b),
    .cmd         (cmd),
    .op_done     (op_done),
    .cur_op      (cur_op)
  );

  // ==============================
  // execute
  // ==============================
  tlboper_seq seq_i (
    .tlboper_clk (tlboper_clk),
    .cpurst_b    (cpurst_b),
    .cur_op      (cur_op),
    .arb_grant   (arb_grant),
    .jtlb_rsp    (jtlb_rsp),
    .phase       (phase),
    .inv_idx     (inv_idx),
    .wr_fifo     (wr_fifo),
    .wr_sel      (wr_sel),
    .op_done     (op_done)
  );

  // ==============================
  // result
  // ==============================
  tlboper_jtlb_req jtlb_req_i (
    .cur_op       (cur_op),
    .phase        (phase),
    .inv_idx      (inv_idx),
    .wr_fifo      (wr_fifo),
    .wr_sel       (wr_sel),
    .op_done      (op_done),
    .entry        (entry),
    .mir          (mir),
    .arb          (arb),
    .tlbp_cmplt   (tlbp_cmplt),
    .tlbr_cmplt   (tlbr_cmplt),
    .cmplt        (cmplt),
    .cp0_tlb_done (cp0_tlb_done)
  );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
// testbench clock and reset source, 8 ns clock with reset held low for two cycles
`default_nettype none

module tb_clk_gen (
  output logic tlboper_clk,
  output logic cpurst_b
);
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    tlboper_clk = 1'b0;
    forever #4 tlboper_clk = ~tlboper_clk;
  end

  // released on a rising edge after two cycles
  initial
  begin
    cpurst_b = 1'b0;
    repeat (2) @(posedge tlboper_clk);
    cpurst_b <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_tlboper.sv
// testbench for the jTLB operation controller, runs each operation against a model arbiter and jTLB
`default_nettype none

`include "tlboper_params.svh"

module tb_tlboper;
  timeunit 1ns;
  timeprecision 1ps;

  // 12 short ops under 30 cycles each plus 256 invall grants under 6 cycles each
  localparam int MAX_CYCLES = 3000;
  localparam int INV_LAST   = `TLBOPER_INVALL_LAST;

  logic                          tlboper_clk;
  logic                          cpurst_b;
  tlboper_pkg::tlb_cmd_t         cmd = '0;
  tlboper_pkg::tlb_entry_t       entry = '0;
  logic [`TLBOPER_MIR_WIDTH-1:0] mir = '0;
  logic                          arb_grant = 1'b0;
  tlboper_pkg::tlb_jtlb_rsp_t    jtlb_rsp = '0;
  tlboper_pkg::tlb_arb_req_t     arb;
  logic                          tlbp_cmplt;
  logic                          tlbr_cmplt;
  logic                          cmplt;
  logic                          cp0_tlb_done;

  // model state
  tlboper_pkg::tlb_op_e          test_op = tlboper_pkg::op_none;
  tlboper_pkg::tlb_arb_req_t     exp_arb;
  logic [`TLBOPER_BANKS-1:0]     cap_fifo = '0;
  logic [`TLBOPER_BANKS-1:0]     cap_sel = '0;
  logic                          op_busy = 1'b0;
  logic                          req_s = 1'b0;
  logic                          grant_s = 1'b0;
  logic                          done_s = 1'b0;
  logic                          rsp_pend = 1'b0;
  logic                          wr_phase;
  logic                          exp_req;
  logic                          exp_done;
  logic                          chk_idx;
  logic                          chk_fifo;
  logic [31:0]                   rnd;
  int                            inv_exp;
  int                            acc_num = 0;
  int                            rsp_num = 0;
  int                            grant_wait = 0;
  int                            rsp_wait = 0;
  int                            cycle_cnt = 0;

  tb_clk_gen clk_gen_i (
    .tlboper_clk (tlboper_clk),
    .cpurst_b    (cpurst_b)
  );

  tlboper_top dut_i (
    .tlboper_clk  (tlboper_clk),
    .cpurst_b     (cpurst_b),
    .cmd          (cmd),
    .entry        (entry),
    .mir          (mir),
    .arb_grant    (arb_grant),
    .jtlb_rsp     (jtlb_rsp),
    .arb          (arb),
    .tlbp_cmplt   (tlbp_cmplt),
    .tlbr_cmplt   (tlbr_cmplt),
    .cmplt        (cmplt),
    .cp0_tlb_done (cp0_tlb_done)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp_val,
                            input logic [63:0] act_val);
    fail_run($sformatf("mismatch at %0t: %s expected %0h actual %0h",
                       $time, name, exp_val, act_val));
  endtask

  function automatic tlboper_pkg::tlb_cmd_t op_strobe(input tlboper_pkg::tlb_op_e op);
    tlboper_pkg::tlb_cmd_t c;
    c.tlbp   = (op == tlboper_pkg::op_tlbp);
    c.tlbr   = (op == tlboper_pkg::op_tlbr);
    c.tlbwi  = (op == tlboper_pkg::op_tlbwi);
    c.tlbwr  = (op == tlboper_pkg::op_tlbwr);
    c.invall = (op == tlboper_pkg::op_invall);
    return c;
  endfunction

  function automatic tlboper_pkg::tlb_entry_t random_entry();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[$bits(tlboper_pkg::tlb_entry_t)-1:0];
  endfunction

  // ==============================
  // expected request model
  // ==============================
  always_comb
  begin
    wr_phase = (test_op == tlboper_pkg::op_tlbwr) && (rsp_num != 0);
    inv_exp  = INV_LAST - acc_num;
    exp_arb  = '0;
    chk_idx  = 1'b0;
    chk_fifo = wr_phase;
    case (test_op)
      tlboper_pkg::op_tlbp:
      begin
        exp_arb.cmp_va   = 1'b1;
        exp_arb.bank_sel = '1;
        exp_arb.vpn      = entry.vpn;
      end
      tlboper_pkg::op_tlbr, tlboper_pkg::op_tlbwi:
      begin
        exp_arb.write      = (test_op == tlboper_pkg::op_tlbwi);
        exp_arb.idx_not_va = 1'b1;
        exp_arb.idx        = mir[`TLBOPER_IDX_WIDTH-1:0];
        exp_arb.bank_sel   = 4'b0001 << mir[`TLBOPER_MIR_WIDTH-1 -: 2];
        chk_idx            = 1'b1;
      end
      tlboper_pkg::op_tlbwr:
      begin
        exp_arb.write      = wr_phase;
        exp_arb.fifo_write = wr_phase;
        exp_arb.bank_sel   = wr_phase ? cap_sel : 4'b1111;
        exp_arb.fifo_din   = {cap_fifo[2:0], cap_fifo[3]};
      end
      tlboper_pkg::op_invall:
      begin
        exp_arb.write      = 1'b1;
        exp_arb.fifo_write = 1'b1;
        exp_arb.idx_not_va = 1'b1;
        exp_arb.bank_sel   = '1;
        exp_arb.idx        = inv_exp[`TLBOPER_IDX_WIDTH-1:0];
        exp_arb.fifo_din   = 4'b0001;
        chk_idx            = 1'b1;
        chk_fifo           = 1'b1;
      end
      default:
      begin
      end
    endcase
    if ((test_op == tlboper_pkg::op_tlbwi) || wr_phase)
    begin
      exp_arb.tag_din  = {1'b1, entry.vpn, entry.asid, entry.pgs, entry.glb};
      exp_arb.data_din = {entry.ppn, entry.flg};
    end
    // one request outstanding at a time, none while its jTLB access runs
    if (test_op == tlboper_pkg::op_invall)
      exp_req = op_busy;
    else
      exp_req = op_busy && (acc_num == rsp_num) && !jtlb_rsp.cmplt;
    // invall ends on its 256th grant, tlbwr on its second jTLB completion
    if (test_op == tlboper_pkg::op_invall)
      exp_done = op_busy && arb_grant && (acc_num == INV_LAST);
    else
      exp_done = jtlb_rsp.cmplt && ((test_op != tlboper_pkg::op_tlbwr) || (rsp_num == 2));
  end

  // ==============================
  // arbiter and jTLB responder
  // ==============================
  always @(negedge tlboper_clk)
  begin
    req_s   <= arb.req;
    grant_s <= arb_grant;
    done_s  <= exp_done;
  end

  always @(posedge tlboper_clk)
  begin
    jtlb_rsp.cmplt <= 1'b0;
    // a strobe only starts an operation when none is running
    if ((cmd != '0) && !op_busy)
      op_busy <= 1'b1;
    if (req_s && grant_s)
    begin
      acc_num    <= acc_num + 1;
      arb_grant  <= 1'b0;
      grant_wait <= $urandom_range(3, 0);
      if (test_op != tlboper_pkg::op_invall)
      begin
        rsp_wait <= $urandom_range(4, 1);
        rsp_pend <= 1'b1;
      end
    end
    else if (req_s && (grant_wait == 0))
      arb_grant <= 1'b1;
    else if (req_s)
      grant_wait <= grant_wait - 1;
    if (rsp_pend && (rsp_wait == 1))
    begin
      rnd = $urandom;
      jtlb_rsp.cmplt <= 1'b1;
      jtlb_rsp.fifo  <= rnd[3:0];
      jtlb_rsp.sel   <= 4'b0001 << rnd[5:4];
      cap_fifo       <= rnd[3:0];
      cap_sel        <= 4'b0001 << rnd[5:4];
      rsp_num        <= rsp_num + 1;
      rsp_pend       <= 1'b0;
    end
    else if (rsp_pend)
      rsp_wait <= rsp_wait - 1;
    if (done_s)
    begin
      op_busy <= 1'b0;
      acc_num <= 0;
      rsp_num <= 0;
    end
  end

  // ==============================
  // checks
  // ==============================
  property field_ok(logic en, logic [63:0] exp_val, logic [63:0] act_val);
    @(posedge tlboper_clk) disable iff (!cpurst_b)
      arb.req && en |-> (act_val == exp_val);
  endproperty

  property pulse_ok(logic exp_val, logic act_val);
    @(posedge tlboper_clk) disable iff (!cpurst_b)
      act_val == exp_val;
  endproperty

  a_req: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    arb.req == exp_req)
    else fail_value("arb.req", $sampled(exp_req), $sampled(arb.req));
  // nothing may move while the arbiter withholds its grant
  a_hold: assert property (@(posedge tlboper_clk) disable iff (!cpurst_b)
    arb.req && !arb_grant |=> $stable(arb))
    else fail_run("the request changed while waiting for a grant");

  a_write: assert property (field_ok(1'b1, exp_arb.write, arb.write))
    else fail_value("arb.write", $sampled(exp_arb.write), $sampled(arb.write));
  a_fifo_write: assert property (field_ok(1'b1, exp_arb.fifo_write, arb.fifo_write))
    else fail_value("arb.fifo_write", $sampled(exp_arb.fifo_write), $sampled(arb.fifo_write));
  a_idx_not_va: assert property (field_ok(1'b1, exp_arb.idx_not_va, arb.idx_not_va))
    else fail_value("arb.idx_not_va", $sampled(exp_arb.idx_not_va), $sampled(arb.idx_not_va));
  a_cmp_va: assert property (field_ok(1'b1, exp_arb.cmp_va, arb.cmp_va))
    else fail_value("arb.cmp_va", $sampled(exp_arb.cmp_va), $sampled(arb.cmp_va));
  a_bank_sel: assert property (field_ok(1'b1, exp_arb.bank_sel, arb.bank_sel))
    else fail_value("arb.bank_sel", $sampled(exp_arb.bank_sel), $sampled(arb.bank_sel));
  a_idx: assert property (field_ok(chk_idx, exp_arb.idx, arb.idx))
    else fail_value("arb.idx", $sampled(exp_arb.idx), $sampled(arb.idx));
  a_vpn: assert property (field_ok(test_op == tlboper_pkg::op_tlbp, exp_arb.vpn, arb.vpn))
    else fail_value("arb.vpn", $sampled(exp_arb.vpn), $sampled(arb.vpn));
  a_tag: assert property (field_ok(1'b1, exp_arb.tag_din, arb.tag_din))
    else fail_value("arb.tag_din", $sampled(exp_arb.tag_din), $sampled(arb.tag_din));
  a_data: assert property (field_ok(1'b1, exp_arb.data_din, arb.data_din))
    else fail_value("arb.data_din", $sampled(exp_arb.data_din), $sampled(arb.data_din));
  a_fifo_din: assert property (field_ok(chk_fifo, exp_arb.fifo_din, arb.fifo_din))
    else fail_value("arb.fifo_din", $sampled(exp_arb.fifo_din), $sampled(arb.fifo_din));

  a_cmplt: assert property (pulse_ok(exp_done, cmplt))
    else fail_value("cmplt", $sampled(exp_done), $sampled(cmplt));
  a_tlbp_cmplt: assert property (pulse_ok(exp_done && (test_op == tlboper_pkg::op_tlbp),
                                          tlbp_cmplt))
    else fail_value("tlbp_cmplt", $sampled(exp_done && (test_op == tlboper_pkg::op_tlbp)),
                    $sampled(tlbp_cmplt));
  a_tlbr_cmplt: assert property (pulse_ok(exp_done && (test_op == tlboper_pkg::op_tlbr),
                                          tlbr_cmplt))
    else fail_value("tlbr_cmplt", $sampled(exp_done && (test_op == tlboper_pkg::op_tlbr)),
                    $sampled(tlbr_cmplt));
  a_cp0_done: assert property (pulse_ok(exp_done && (test_op == tlboper_pkg::op_invall),
                                        cp0_tlb_done))
    else fail_value("cp0_tlb_done", $sampled(exp_done && (test_op == tlboper_pkg::op_invall)),
                    $sampled(cp0_tlb_done));

  // ==============================
  // stimulus
  // ==============================
  task automatic run_op(input tlboper_pkg::tlb_op_e op, input logic busy);
    logic [31:0]          r32;
    tlboper_pkg::tlb_op_e busy_op;
    busy_op = (op == tlboper_pkg::op_invall) ? tlboper_pkg::op_tlbp : tlboper_pkg::op_invall;
    r32 = $urandom;
    @(posedge tlboper_clk);
    entry   <= random_entry();
    mir     <= r32[`TLBOPER_MIR_WIDTH-1:0];
    test_op <= op;
    cmd     <= op_strobe(op);
    @(posedge tlboper_clk);
    // second strobe lands while the first operation runs
    if (busy)
      cmd <= op_strobe(busy_op);
    else
      cmd <= tlboper_pkg::tlb_cmd_t'(0);
    @(posedge tlboper_clk);
    cmd <= tlboper_pkg::tlb_cmd_t'(0);
    do
      @(negedge tlboper_clk);
    while (!cmplt);
  endtask

  always @(posedge tlboper_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      fail_run("timeout, the operations did not finish within the cycle limit");
  end

  initial
  begin
    void'($urandom(32'heaa0));
    @(posedge cpurst_b);
    repeat (3) @(posedge tlboper_clk);
    for (int rep = 0; rep < 3; rep++)
    begin
      run_op(tlboper_pkg::op_tlbp, rep == 1);
      run_op(tlboper_pkg::op_tlbr, rep == 1);
      run_op(tlboper_pkg::op_tlbwi, rep == 1);
      run_op(tlboper_pkg::op_tlbwr, rep == 1);
    end
    run_op(tlboper_pkg::op_invall, 1'b1);
    repeat (4) @(posedge tlboper_clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/tlboper_pkg.sv
tlboper/tlboper_decode.sv
tlboper/tlboper_seq.sv
tlboper/tlboper_jtlb_req.sv
tlboper/tlboper_top.sv
sim/tb_clk_gen.sv
sim/tb_tlboper.sv

// File: Bender.yml
package:
  name: tlboper

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tlboper_pkg.sv
      - tlboper/tlboper_decode.sv
      - tlboper/tlboper_seq.sv
      - tlboper/tlboper_jtlb_req.sv
      - tlboper/tlboper_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_tlboper.sv
